//--- build.f
+incdir+sim
hw/arithPkg.sv
hw/PrefixAnd.sv
hw/LeadZeroDet.sv
hw/PosEncode.sv
hw/IntToFloatLane.sv
hw/ResultArbiter.sv
hw/ConvTop.sv
sim/ConvTb.sv

//--- sim/convVectors.svh
`ifndef CONV_VECTORS_SVH
`define CONV_VECTORS_SVH

// columns: test name, lane, integer in, expected float out
typedef struct {
	string name;
	laneIdT lane;
	wordT data;
	floatT expFloat;
} convVecT;

convVecT vecTable [$];

function automatic void addVec(input string name, input laneIdT lane, input wordT data,
		input floatT expFloat);
	convVecT row;
	row.name = name;
	row.lane = lane;
	row.data = data;
	row.expFloat = expFloat;
	vecTable.push_back(row);
endfunction

// floats worked out by hand, truncated toward zero, bias 127
task automatic loadVectors();
	// small values and signs, lanes alternate
	addVec("zero", 0, 32'h0000_0000, 32'h0000_0000);
	addVec("one", 1, 32'h0000_0001, 32'h3F80_0000);
	addVec("minus_one", 0, 32'hFFFF_FFFF, 32'hBF80_0000);
	addVec("two", 1, 32'h0000_0002, 32'h4000_0000);
	addVec("three", 0, 32'h0000_0003, 32'h4040_0000);
	addVec("neg_five", 1, 32'hFFFF_FFFB, 32'hC0A0_0000);
	addVec("hundred", 0, 32'h0000_0064, 32'h42C8_0000);
	addVec("neg_hundred", 1, 32'hFFFF_FF9C, 32'hC2C8_0000);
	// powers of two and both range ends
	addVec("pow2_6", 0, 32'h0000_0040, 32'h4280_0000);
	addVec("pow2_10", 1, 32'h0000_0400, 32'h4480_0000);
	addVec("pow2_30", 0, 32'h4000_0000, 32'h4E80_0000);
	addVec("neg_pow2_30", 1, 32'hC000_0000, 32'hCE80_0000);
	addVec("max_pos", 0, 32'h7FFF_FFFF, 32'h4EFF_FFFF);
	addVec("most_neg", 1, 32'h8000_0000, 32'hCF00_0000);
	// low bits fall off the mantissa
	addVec("trunc_2p24p1", 0, 32'h0100_0001, 32'h4B80_0000);
	addVec("trunc_01234567", 1, 32'h0123_4567, 32'h4B91_A2B3);
	addVec("trunc_neg01234567", 0, 32'hFEDC_BA99, 32'hCB91_A2B3);
	addVec("trunc_12345678", 1, 32'h1234_5678, 32'h4D91_A2B3);
	addVec("trunc_2p30p1", 0, 32'h4000_0001, 32'h4E80_0000);
	addVec("trunc_2p28m1", 1, 32'h0FFF_FFFF, 32'h4D7F_FFFF);
	addVec("trunc_neg2p28m1", 0, 32'hF000_0001, 32'hCD7F_FFFF);
	// fits exactly in 24 bits
	addVec("exact_2p23p1", 1, 32'h0080_0001, 32'h4B00_0001);
	addVec("exact_2p24m1", 0, 32'h00FF_FFFF, 32'h4B7F_FFFF);
	addVec("byte_max", 1, 32'h0000_00FF, 32'h437F_0000);
	// one lane only, order inside a lane
	addVec("burst_seven", 0, 32'h0000_0007, 32'h40E0_0000);
	addVec("burst_eight", 0, 32'h0000_0008, 32'h4100_0000);
	addVec("burst_nine", 0, 32'h0000_0009, 32'h4110_0000);
	addVec("burst_ten", 0, 32'h0000_000A, 32'h4120_0000);
	addVec("burst_neg_seven", 1, 32'hFFFF_FFF9, 32'hC0E0_0000);
	addVec("burst_neg_eight", 1, 32'hFFFF_FFF8, 32'hC100_0000);
endtask

`endif

//--- sim/ConvTb.sv
`timescale 1ns/100ps

module ConvTb;
	import arithPkg::*;

	localparam int laneDepth = 2;
	localparam int outCredits = 2;
	localparam int speed = 1;

	`include "convVectors.svh"

	logic clk;
	logic rstN;
	logic in0Valid;
	wordT in0Data;
	logic in0Credit;
	logic in1Valid;
	wordT in1Data;
	logic in1Credit;
	logic outValid;
	floatT outData;
	laneIdT outLane;
	logic outCredit;

	// source credit model
	int srcCredits [numLanes];
	int issued [numLanes];
	int creditPulses [numLanes];
	// table rows in flight per lane
	int pendQ [numLanes][$];
	// lane queue fill rebuilt from the pins
	int occ [numLanes];
	logic accNext [numLanes];
	// sink credit model
	int owed;
	int returned;
	int gap;
	int cycle;
	int resultCount;
	laneIdT lastLane;
	bit haveLast;
	int numTests;
	bit tableReady;
	int passCount;
	int failCount;

	ConvTop #(
		.laneDepth(laneDepth),
		.outCredits(outCredits),
		.speed(speed)
	) dut_i (
		.clk(clk),
		.rstN(rstN),
		.in0Valid(in0Valid),
		.in0Data(in0Data),
		.in0Credit(in0Credit),
		.in1Valid(in1Valid),
		.in1Data(in1Data),
		.in1Credit(in1Credit),
		.outValid(outValid),
		.outData(outData),
		.outLane(outLane),
		.outCredit(outCredit)
	);

	always #20 clk = ~clk;

	task automatic checkFloat(input string name, input string what, input floatT expV,
			input floatT actV, inout bit ok);
		if (actV !== expV) begin
			$display("[ERROR] %s %s expected %h actual %h", name, what, expV, actV);
			ok = 1'b0;
		end
	endtask

	task automatic checkLane(input string name, input string what, input laneIdT expV,
			input laneIdT actV, inout bit ok);
		if (actV !== expV) begin
			$display("[ERROR] %s %s expected %0d actual %0d", name, what, expV, actV);
			ok = 1'b0;
		end
	endtask

	task automatic checkCount(input string name, input string what, input int expV,
			input int actV, inout bit ok);
		if (actV != expV) begin
			$display("[ERROR] %s %s expected %0d actual %0d", name, what, expV, actV);
			ok = 1'b0;
		end
	endtask

	task automatic finishTest(input string name, input bit ok);
		if (ok) begin
			passCount++;
			$display("[PASS] %s", name);
		end else begin
			failCount++;
			$display("[FAIL] %s", name);
		end
	endtask

	// sink returns one credit per result after a random gap and holds them back in stretches
	always @(posedge clk) begin
		if (rstN) begin
			cycle++;
			outCredit <= 1'b0;
			if (gap > 0) begin
				gap--;
			end else if (owed > 0 && (cycle % 40) < 28) begin
				outCredit <= 1'b1;
				owed--;
				returned++;
				gap = $urandom % 4;
			end
		end
	end

	// outputs sampled mid-cycle
	always @(negedge clk) begin
		bit ok;
		bit bothReq;
		int idx;
		string name;
		if (rstN) begin
			// both lanes were requesting at the last edge
			bothReq = (occ[0] > 0) && (occ[1] > 0);
			if (in0Credit) begin
				srcCredits[0]++;
				creditPulses[0]++;
			end
			if (in1Credit) begin
				srcCredits[1]++;
				creditPulses[1]++;
			end
			if (outValid) begin
				ok = 1'b1;
				name = "unmatched_result";
				resultCount++;
				owed++;
				if (resultCount > outCredits + returned) begin
					$display("result %0d sent with only %0d sink credits given",
						resultCount, outCredits + returned);
					ok = 1'b0;
				end
				if (pendQ[outLane].size() == 0) begin
					$display("lane %0d sent a result with no input waiting", outLane);
					ok = 1'b0;
				end else begin
					idx = pendQ[outLane].pop_front();
					name = vecTable[idx].name;
					checkFloat(name, "float", vecTable[idx].expFloat, outData, ok);
				end
				// other lane wins when both wait
				if (bothReq && haveLast) begin
					checkLane(name, "round-robin lane",
						laneIdT'((int'(lastLane) + 1) % numLanes), outLane, ok);
				end
				lastLane = outLane;
				haveLast = 1'b1;
				finishTest(name, ok);
			end
			for (int l = 0; l < numLanes; l++) begin
				occ[l] = occ[l] + int'(accNext[l]) - int'(outValid && outLane == laneIdT'(l));
			end
			// accepted at the coming edge
			accNext[0] = in0Valid;
			accNext[1] = in1Valid;
		end
	end

	initial begin
		int idx;
		convVecT v;
		bit ok;
		string name;
		clk = 1'b0;
		rstN = 1'b0;
		in0Valid = 1'b0;
		in0Data = '0;
		in1Valid = 1'b0;
		in1Data = '0;
		outCredit = 1'b0;
		for (int l = 0; l < numLanes; l++) begin
			srcCredits[l] = laneDepth;
			accNext[l] = 1'b0;
		end
		void'($urandom(91254));
		loadVectors();
		numTests = vecTable.size();
		tableReady = 1'b1;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		idx = 0;
		while (idx < numTests) begin
			@(posedge clk);
			in0Valid <= 1'b0;
			in1Valid <= 1'b0;
			v = vecTable[idx];
			// row waits for a credit on its own lane
			if (srcCredits[v.lane] > 0) begin
				srcCredits[v.lane]--;
				issued[v.lane]++;
				pendQ[v.lane].push_back(idx);
				if (v.lane == 0) begin
					in0Valid <= 1'b1;
					in0Data <= v.data;
				end else begin
					in1Valid <= 1'b1;
					in1Data <= v.data;
				end
				idx++;
			end
		end
		@(posedge clk);
		in0Valid <= 1'b0;
		in1Valid <= 1'b0;
		wait (resultCount == numTests);
		// last credits drain after the final result
		for (int k = 0; k < 40; k++) begin
			if (srcCredits[0] == laneDepth && srcCredits[1] == laneDepth && owed == 0) begin
				break;
			end
			@(negedge clk);
		end
		for (int l = 0; l < numLanes; l++) begin
			ok = 1'b1;
			name = $sformatf("credit_return_lane%0d", l);
			checkCount(name, "inCredit pulses", issued[l], creditPulses[l], ok);
			checkCount(name, "source credits", laneDepth, srcCredits[l], ok);
			finishTest(name, ok);
		end
		ok = 1'b1;
		checkCount("result_totals", "results", numTests, resultCount, ok);
		checkCount("result_totals", "rows left", 0, pendQ[0].size() + pendQ[1].size(), ok);
		finishTest("result_totals", ok);
		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// run length scales with the table
	initial begin
		wait (tableReady);
		repeat (numTests * 20 + 100) @(posedge clk);
		$display("timed out after %0d clock periods with %0d of %0d results seen",
			numTests * 20 + 100, resultCount, numTests);
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- hw/ConvTop.sv
`timescale 1ns/100ps

module ConvTop #(
	parameter int laneDepth = 2,
	parameter int outCredits = 2,
	parameter int speed = 1
) (
	input  logic clk,
	input  logic rstN,
	// lane 0 source
	input  logic in0Valid,
	input  arithPkg::wordT in0Data,
	output logic in0Credit,
	// lane 1 source
	input  logic in1Valid,
	input  arithPkg::wordT in1Data,
	output logic in1Credit,
	// shared result bus
	output logic outValid,
	output arithPkg::floatT outData,
	output arithPkg::laneIdT outLane,
	input  logic outCredit
);
	import arithPkg::*;

	// lane to arbiter handshake
	logic [numLanes-1:0] reqValid;
	floatT reqData [numLanes];
	logic [numLanes-1:0] grant;

	IntToFloatLane #(
		.laneDepth(laneDepth),
		.speed(speed)
	) lane0_i (
		.clk(clk),
		.rstN(rstN),
		.inValid(in0Valid),
		.inData(in0Data),
		.inCredit(in0Credit),
		.reqValid(reqValid[0]),
		.reqData(reqData[0]),
		.grant(grant[0])
	);

	IntToFloatLane #(
		.laneDepth(laneDepth),
		.speed(speed)
	) lane1_i (
		.clk(clk),
		.rstN(rstN),
		.inValid(in1Valid),
		.inData(in1Data),
		.inCredit(in1Credit),
		.reqValid(reqValid[1]),
		.reqData(reqData[1]),
		.grant(grant[1])
	);

	// round-robin onto the single result bus
	ResultArbiter #(
		.outCredits(outCredits)
	) arbiter_i (
		.clk(clk),
		.rstN(rstN),
		.reqValid(reqValid),
		.reqData(reqData),
		.grant(grant),
		.outValid(outValid),
		.outData(outData),
		.outLane(outLane),
		.outCredit(outCredit)
	);

endmodule

//--- hw/ResultArbiter.sv
`timescale 1ns/100ps

module ResultArbiter #(
	parameter int outCredits = 2
) (
	input  logic clk,
	input  logic rstN,
	// lane requests
	input  logic [arithPkg::numLanes-1:0] reqValid,
	input  arithPkg::floatT reqData [arithPkg::numLanes],
	output logic [arithPkg::numLanes-1:0] grant,
	// result bus
	output logic outValid,
	output arithPkg::floatT outData,
	output arithPkg::laneIdT outLane,
	input  logic outCredit
);
	import arithPkg::*;

	localparam int creditW = $clog2(outCredits + 1);

	typedef logic [creditW-1:0] creditT;

	// sink credits still available
	creditT credits;
	logic canGrant;
	// lane checked first
	laneIdT prio;
	laneIdT winner;
	logic found;

	assign canGrant = (credits != '0);

	// first requester at or after the priority pointer
	always_comb begin
		found = 1'b0;
		winner = prio;
		for (int i = 0; i < numLanes; i++) begin
			if (!found && canGrant && reqValid[(int'(prio) + i) % numLanes]) begin
				found = 1'b1;
				winner = laneIdT'((int'(prio) + i) % numLanes);
			end
		end
		grant = '0;
		if (found) begin
			grant[winner] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			credits <= creditT'(outCredits);
			prio <= '0;
			outValid <= 1'b0;
		end else begin
			// spend and refill may land on the same edge
			credits <= credits - creditT'(found) + creditT'(outCredit);
			if (found) begin
				// granted lane drops to lowest priority
				prio <= laneIdT'((int'(winner) + 1) % numLanes);
			end
			outValid <= found;
		end
	end

	// result payload, qualified by outValid
	always_ff @(posedge clk) begin
		if (found) begin
			outData <= reqData[winner];
			outLane <= winner;
		end
	end

endmodule

//--- hw/IntToFloatLane.sv
`timescale 1ns/100ps

module IntToFloatLane #(
	parameter int laneDepth = 2,
	parameter int speed = 1
) (
	input  logic clk,
	input  logic rstN,
	// source side
	input  logic inValid,
	input  arithPkg::wordT inData,
	output logic inCredit,
	// arbiter side
	output logic reqValid,
	output arithPkg::floatT reqData,
	input  logic grant
);
	import arithPkg::*;

	localparam int ptrW = (laneDepth > 1) ? $clog2(laneDepth) : 1;
	localparam int cntW = $clog2(laneDepth + 1);

	typedef logic [ptrW-1:0] ptrT;
	typedef logic [cntW-1:0] cntT;

	// raw integers waiting for the arbiter
	wordT queue [laneDepth];
	ptrT rdPtr;
	ptrT wrPtr;
	cntT fill;
	logic pop;

	// conversion of the head entry
	wordT head;
	logic sign;
	logic [wordBits-1:0] mag;
	logic [wordBits-1:0] oneHot;
	lzCountT lzCount;
	logic [wordBits-1:0] norm;
	logic [expBits-1:0] expField;
	logic [manBits-1:0] manField;

	// circular advance
	function automatic ptrT nextPtr(input ptrT ptr);
		return (ptr == ptrT'(laneDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// head leaves on a grant
	assign pop = grant & reqValid;
	assign reqValid = (fill != '0);

	// source never writes into a full queue
	always_ff @(posedge clk) begin
		if (inValid) begin
			queue[wrPtr] <= inData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			fill <= '0;
			inCredit <= 1'b0;
		end else begin
			if (inValid) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			fill <= fill + cntT'(inValid) - cntT'(pop);
			// one credit back per popped entry
			inCredit <= pop;
		end
	end

	assign head = queue[rdPtr];
	assign sign = head[wordBits-1];

	// two's complement magnitude, most negative value stays 2^31 unsigned
	assign mag = sign ? -head : head;

	LeadZeroDet #(
		.width(wordBits),
		.speed(speed)
	) lzd_i (
		.A(mag),
		.Z(oneHot)
	);

	PosEncode #(
		.width(wordBits)
	) enc_i (
		.oneHot(oneHot),
		.count(lzCount)
	);

	// leading one lands on the MSB
	assign norm = mag << lzCount;
	assign expField = expBits'(expBias + wordBits - 1) - expBits'(lzCount);
	// hidden bit dropped, low bits truncated
	assign manField = norm[wordBits-2 -: manBits];

	// zero has no leading one
	assign reqData = (mag == '0) ? floatZero : {sign, expField, manField};

endmodule

//--- hw/PosEncode.sv
`timescale 1ns/100ps

module PosEncode #(
	parameter int width = 32
) (
	// one-hot leading-one position
	input  logic [width-1:0] oneHot,
	// zeros above that position
	output arithPkg::lzCountT count
);

	// bit positions whose zero count has bit b set
	function automatic logic [width-1:0] bitMask(input int b);
		logic [width-1:0] mask;
		mask = '0;
		for (int i = 0; i < width; i++) begin
			mask[i] = (((width - 1 - i) >> b) & 1) != 0;
		end
		return mask;
	endfunction

	// one OR tree per count bit
	for (genvar b = 0; b < $bits(count); b++) begin : encBit
		localparam logic [width-1:0] sel = bitMask(b);

		// all-zero input falls out as count 0
		assign count[b] = |(oneHot & sel);
	end

endmodule

//--- hw/LeadZeroDet.sv
`timescale 1ns/100ps

module LeadZeroDet #(
	parameter int width = 8,
	parameter int speed = 0
) (
	// operand
	input  logic [width-1:0] A,
	// one-hot position of the first set bit from the MSB
	output logic [width-1:0] Z
);

	// inverted operand, MSB moved to bit 0
	logic [width-1:0] revIn;
	// prefix result in reversed order
	logic [width-1:0] revOut;
	// bit i set while A[width-1:i] is all zero
	logic [width-1:0] zeroAbove;

	for (genvar i = 0; i < width; i++) begin : flipIn
		assign revIn[i] = ~A[width-1-i];
	end

	// zero run scan starting at the MSB
	PrefixAnd #(
		.width(width),
		.speed(speed)
	) prefixAnd_i (
		.PI(revIn),
		.PO(revOut)
	);

	for (genvar i = 0; i < width; i++) begin : flipOut
		assign zeroAbove[i] = revOut[width-1-i];
	end

	// MSB needs no zero run above it
	assign Z[width-1] = A[width-1];

	// keep a set bit only when everything above is clear
	for (genvar i = 0; i < width - 1; i++) begin : pick
		assign Z[i] = A[i] & zeroAbove[i+1];
	end

endmodule

//--- hw/PrefixAnd.sv
`timescale 1ns/100ps

module PrefixAnd #(
	parameter int width = 8,
	parameter int speed = 0
) (
	// propagate in
	input  logic [width-1:0] PI,
	// running AND from bit 0 upwards
	output logic [width-1:0] PO
);

	localparam int n = width;
	// tree depth, at least one level
	localparam int m = (width > 1) ? $clog2(width) : 1;

	if (speed == 2) begin : sklansky
		// one row per level, row 0 is the input
		logic [m:0][n-1:0] pt;

		assign pt[0] = PI;

		for (genvar l = 1; l <= m; l++) begin : level
			// half block size at this level
			localparam int h = 2 ** (l - 1);

			for (genvar i = 0; i < n; i++) begin : bitSlot
				if (((i / h) % 2) == 1) begin : node
					// upper half takes the last bit of the lower half
					assign pt[l][i] = pt[l-1][i] & pt[l-1][(i / h) * h - 1];
				end else begin : pass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		assign PO = pt[m];
	end else if (speed == 1) begin : brentKung
		// m up-sweep levels then m-1 down-sweep levels
		logic [2*m-1:0][n-1:0] pt;

		assign pt[0] = PI;

		// up-sweep, builds power-of-two blocks
		for (genvar l = 1; l <= m; l++) begin : upLevel
			for (genvar i = 0; i < n; i++) begin : upBit
				if (((i + 1) % (2 ** l)) == 0) begin : node
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i - 2 ** (l - 1)];
				end else begin : pass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		// down-sweep, fills the odd block ends
		for (genvar l = m + 1; l < 2 * m; l++) begin : downLevel
			// block span halves at each step
			localparam int s = 2 * m - 1 - l;

			for (genvar i = 0; i < n; i++) begin : downBit
				if ((i >= 2 ** (s + 1)) && (((i + 1) % (2 ** (s + 1))) == 2 ** s)) begin : node
					// left neighbour already holds the full prefix
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i - 2 ** s];
				end else begin : pass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		assign PO = pt[2*m-1];
	end else begin : serial
		// ripple chain, smallest and slowest
		logic [n-1:0] pt;

		assign pt[0] = PI[0];

		for (genvar i = 1; i < n; i++) begin : chain
			assign pt[i] = PI[i] & pt[i-1];
		end

		assign PO = pt;
	end

endmodule

//--- hw/arithPkg.sv
package arithPkg;

	// integer operand width
	localparam int wordBits = 32;

	// single precision field widths
	localparam int expBits = 8;
	localparam int manBits = 23;

	// exponent bias of the float format
	localparam int expBias = 127;

	// peer conversion lanes sharing the result bus
	localparam int numLanes = 2;

	// signed integer operand
	typedef logic signed [wordBits-1:0] wordT;

	// packed sign, exponent, mantissa
	typedef logic [expBits+manBits:0] floatT;

	// leading-zero count of a word
	typedef logic [$clog2(wordBits)-1:0] lzCountT;

	// tag of the producing lane
	typedef logic [$clog2(numLanes)-1:0] laneIdT;

	// result for an all-zero input, positive zero
	localparam floatT floatZero = '0;

endpackage
